// File: vlog.f
+incdir+source
source/positTypesPkg.sv
source/sqrtApproxPkg.sv
source/decodedPositIf.sv
source/positDecoder.sv
source/positSqrtCore.sv
source/positEncoder.sv
source/positSqrtUnit.sv
testbench/positSqrtChecker.sv
testbench/positSqrtTb.sv

// File: testbench/posit_sqrt_stim.txt
// columns: operand (hex), expected sqrt (hex), test group (decimal)
// posit32 es=2, expected values are correctly rounded to nearest even
40000000 40000000 1  // 1
50000000 48000000 1  // 4
30000000 38000000 1  // 0.25
60000000 50000000 1  // 16
20000000 30000000 1  // 1/16
7FFFFFFF 7FFF8000 1  // maxpos
00000001 00008000 1  // minpos
48000000 43504F33 2  // 2
58000000 4B504F33 2  // 8
38000000 3B504F33 2  // 0.5
28000000 33504F33 2  // 0.125
00000000 00000000 3  // zero
80000000 80000000 3  // NaR
C0000000 80000000 3  // -1
B0000000 80000000 3  // -4
FFFFFFFF 80000000 3  // -minpos
40820000 40400000 4  // even scale, segment 0
41080000 40800000 4
42200000 41000000 4
43480000 41800000 4
44800000 42000000 4
45C80000 42800000 4
46720000 42C00000 4
47200000 43000000 4  // even scale, segment 7
48440000 43800000 4  // odd scale, segment 0
49000000 44000000 4
4A900000 45000000 4
4B640000 45800000 4
4C400000 46000000 4
4D240000 46800000 4
4E100000 47000000 4
4F040000 47800000 4  // odd scale, segment 7
4C000000 45DB3D74 4  // 3
52000000 48F1BBCE 4  // 5
40000000 40000000 5
49000000 44000000 5
00000000 00000000 5
C0000000 80000000 5
58000000 4B504F33 5
4C000000 45DB3D74 5

// File: testbench/positSqrtTb.sv
`timescale 1ns/100ps

module positSqrtTb;
  import positTypesPkg::*;

  localparam int clkPeriod = 100;
  localparam int maxTests = 64;
  localparam int maxGroup = 15;

  logic      clk;
  logic      rstN;
  logic      inValid;
  positWordT inPosit;
  logic      outValid;
  positWordT outPosit;

  positWordT   stimOperand [maxTests];
  positWordT   stimExpected [maxTests];
  int          stimGroup [maxTests];
  int          numTests;
  bit          stimLoaded;
  bit          setupError;
  logic [31:0] rngState;

  positSqrtUnit DUT (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inPosit  (inPosit),
    .outValid (outValid),
    .outPosit (outPosit)
  );

  positSqrtChecker resultCheck (
    .clk      (clk),
    .rstN     (rstN),
    .outValid (outValid),
    .outPosit (outPosit)
  );

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // each data line is operand, expected root, group; other lines are skipped.
  task automatic loadStimulus();
    int                 fd;
    int                 status;
    int                 fields;
    logic [8*120-1:0]   lineText;
    logic [31:0]        opVal;
    logic [31:0]        expVal;
    int                 grpVal;
    numTests = 0;
    fd = $fopen("testbench/posit_sqrt_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/posit_sqrt_stim.txt");
      setupError = 1'b1;
      return;
    end
    while (!$feof(fd) && numTests < maxTests) begin
      lineText = '0;
      status = $fgets(lineText, fd);
      fields = $sscanf(lineText, "%h %h %d", opVal, expVal, grpVal);
      if (status > 0 && fields == 3) begin
        if (grpVal < 1 || grpVal > maxGroup) begin
          $display("stimulus line %0d has a bad group number %0d", numTests, grpVal);
          setupError = 1'b1;
        end else begin
          stimOperand[numTests] = opVal;
          stimExpected[numTests] = expVal;
          stimGroup[numTests] = grpVal;
          numTests++;
        end
      end
    end
    $fclose(fd);
  endtask

  // let the pipeline drain before a group is reported.
  task automatic closeGroup(input int group);
    wait (resultCheck.pendingCount == 0);
    @(negedge clk);
    resultCheck.reportGroup(group);
  endtask

  initial begin
    int gap;
    int prevGroup;
    rstN = 1'b0;
    inValid = 1'b0;
    inPosit = '0;
    rngState = 32'h1f052da3;
    setupError = 1'b0;
    loadStimulus();
    if (numTests == 0) begin
      $display("no tests found in the stimulus file");
      setupError = 1'b1;
    end
    stimLoaded = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    // outValid must stay low in these idle cycles.
    repeat (3) @(negedge clk);
    prevGroup = -1;
    for (int i = 0; i < numTests; i++) begin
      if (stimGroup[i] != prevGroup) begin
        if (prevGroup >= 0) begin
          closeGroup(prevGroup);
        end
        prevGroup = stimGroup[i];
      end
      // group 5 runs back to back.
      if (stimGroup[i] == 5) begin
        gap = 0;
      end else begin
        rngState = nextRandom(rngState);
        gap = rngState[1:0];
      end
      repeat (gap) @(negedge clk);
      inValid = 1'b1;
      inPosit = stimOperand[i];
      resultCheck.pushExpected(stimExpected[i], stimGroup[i]);
      @(negedge clk);
      inValid = 1'b0;
    end
    if (prevGroup >= 0) begin
      closeGroup(prevGroup);
    end
    repeat (4) @(negedge clk);
    resultCheck.finalCheck();
    $display("summary: %0d tests, %0d results checked, %0d errors",
             numTests, resultCheck.checkCount, resultCheck.errorCount);
    if (!setupError && resultCheck.errorCount == 0 &&
        resultCheck.checkCount == numTests) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // five cycles per test covers the worst gap plus the pipeline.
  initial begin
    int watchCycles;
    wait (stimLoaded);
    watchCycles = numTests * 5 + 20;
    #(watchCycles * clkPeriod);
    $display("watchdog expired after %0d cycles with results still missing", watchCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: testbench/positSqrtChecker.sv
`timescale 1ns/100ps

module positSqrtChecker (
  input logic                     clk,
  input logic                     rstN,
  input logic                     outValid,
  input positTypesPkg::positWordT outPosit
);
  import positTypesPkg::*;

  localparam int maxGroups = 16;

  positWordT expQueue [$];
  int        groupQueue [$];
  int        pendingCount;
  int        checkCount;
  int        errorCount;
  int        groupChecked [maxGroups];
  int        groupFailed [maxGroups];
  positWordT expValue;
  int        expGroup;

  task automatic pushExpected(input positWordT value, input int group);
    expQueue.push_back(value);
    groupQueue.push_back(group);
    pendingCount = expQueue.size();
  endtask

  task automatic reportGroup(input int group);
    $display("group %0d done: %0d checked, %0d mismatched",
             group, groupChecked[group], groupFailed[group]);
  endtask

  task automatic finalCheck();
    if (expQueue.size() != 0) begin
      $display("%0d expected results never came out of the DUT", expQueue.size());
      errorCount += expQueue.size();
    end
  endtask

  // registered outputs are settled at the rising edge.
  always @(posedge clk) begin
    if (rstN) begin
      if ($isunknown(outValid)) begin
        $display("outValid is unknown at time %0t", $time);
        errorCount++;
      end else if (outValid) begin
        if (expQueue.size() == 0) begin
          $display("outValid high at time %0t with no result pending", $time);
          errorCount++;
        end else begin
          expValue = expQueue.pop_front();
          expGroup = groupQueue.pop_front();
          pendingCount = expQueue.size();
          checkCount++;
          groupChecked[expGroup]++;
          if (outPosit !== expValue) begin
            $display("[FAIL] t=%0t outPosit expected %08h got %08h",
                     $time, expValue, outPosit);
            errorCount++;
            groupFailed[expGroup]++;
          end
        end
      end
    end
  end

endmodule

// File: source/positSqrtUnit.sv
`timescale 1ns/100ps

module positSqrtUnit (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     inValid,
  input  positTypesPkg::positWordT inPosit,
  output logic                     outValid,
  output positTypesPkg::positWordT outPosit
);
  import positTypesPkg::*;

  logic     rootValid;
  scaleT    rootScale;
  rootMantT rootMant;
  logic     rootZero;
  logic     rootNaR;

  decodedPositIf decBus ();

  positDecoder decoder (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .inPosit (inPosit),
    .dec     (decBus.producer)
  );

  positSqrtCore core (
    .clk       (clk),
    .rstN      (rstN),
    .dec       (decBus.consumer),
    .rootValid (rootValid),
    .rootScale (rootScale),
    .rootMant  (rootMant),
    .rootZero  (rootZero),
    .rootNaR   (rootNaR)
  );

  positEncoder encoder (
    .clk       (clk),
    .rstN      (rstN),
    .rootValid (rootValid),
    .rootScale (rootScale),
    .rootMant  (rootMant),
    .rootZero  (rootZero),
    .rootNaR   (rootNaR),
    .outValid  (outValid),
    .outPosit  (outPosit)
  );

endmodule

// File: source/positEncoder.sv
`timescale 1ns/100ps
`include "posit_cfg.svh"

module positEncoder (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     rootValid,
  input  positTypesPkg::scaleT     rootScale,
  input  positTypesPkg::rootMantT  rootMant,
  input  logic                     rootZero,
  input  logic                     rootNaR,
  output logic                     outValid,
  output positTypesPkg::positWordT outPosit
);
  import positTypesPkg::*;

  localparam int wordW = `POSIT_N;
  localparam int expW = `POSIT_ES;
  localparam int packW = 3*wordW + expW + 1;

  scaleT                   kVal;
  scaleT                   runShift;
  logic                    runBit;
  logic signed [packW-1:0] packVec;
  logic signed [packW-1:0] shiftVec;
  logic [wordW-2:0]        body;
  logic                    guardBit;
  logic                    stickyBit;
  logic                    roundUp;
  logic [wordW-2:0]        bodyRnd;
  positWordT               resultWord;

  assign kVal = rootScale >>> expW;
  assign runBit = ~kVal[$bits(scaleT)-1];

  // a run of k+1 ones or -k zeros with one run bit already in place.
  assign runShift = runBit ? kVal : ~kVal;

  // low zero pad keeps shifted out bits visible to the sticky.
  assign packVec = {runBit, ~runBit, rootScale[expW-1:0], rootMant[2*wordW-2:0],
                    {wordW{1'b0}}};
  assign shiftVec = packVec >>> runShift;

  assign body = shiftVec[packW-1 -: wordW-1];
  assign guardBit = shiftVec[packW-wordW];
  assign stickyBit = |shiftVec[packW-wordW-1:0];

  // nearest even that saturates at maxpos.
  assign roundUp = guardBit & (stickyBit | body[0]) & ~(&body);

  always_comb begin
    bodyRnd = body + roundUp;
    // a nonzero root never rounds down to zero.
    if (bodyRnd == '0) begin
      bodyRnd = {{(wordW-2){1'b0}}, 1'b1};
    end
    if (rootNaR) begin
      resultWord = {1'b1, {(wordW-1){1'b0}}};
    end else if (rootZero) begin
      resultWord = '0;
    end else begin
      resultWord = {1'b0, bodyRnd};
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= rootValid;
    end
  end

  always_ff @(posedge clk) begin
    if (rootValid) begin
      outPosit <= resultWord;
    end
  end

endmodule

// File: source/positSqrtCore.sv
`timescale 1ns/100ps
`include "posit_cfg.svh"

module positSqrtCore (
  input  logic                    clk,
  input  logic                    rstN,
  decodedPositIf.consumer         dec,
  output logic                    rootValid,
  output positTypesPkg::scaleT    rootScale,
  output positTypesPkg::rootMantT rootMant,
  output logic                    rootZero,
  output logic                    rootNaR
);
  import positTypesPkg::*;
  import sqrtApproxPkg::*;

  localparam int wordW = `POSIT_N;

  // 3.0 aligned with the m*r^2 product.
  localparam logic [3*wordW-1:0] threeFix = {2'b11, {(3*wordW-2){1'b0}}};
  localparam logic [63:0] sqrtTwo64 = 64'hB504F333F9DE6800;
  localparam rootMantT oneRoot = {1'b1, {(2*wordW-1){1'b0}}};
  localparam rootMantT sqrtTwoRoot =
    rootMantT'({sqrtTwo64, {(2*wordW){1'b0}}} >> 64);

  scaleT                 fullScale;
  logic                  oddScale;
  logic                  negInput;
  logic [31:0]           mant32;
  logic [seedIndexW-1:0] segment;
  logic [31:0]           slope;
  logic [31:0]           intercept;
  logic [63:0]           slopeProd;
  logic [31:0]           seedSum;
  logic [31:0]           seed32;
  logic [2*wordW-1:0]    finalProd;
  rootMantT              mantOut;

  assign fullScale = $signed({dec.regime, dec.exponent});
  assign oddScale = fullScale[0];
  assign negInput = dec.sign & ~dec.isZero;

  // the seed tables work on a 32-bit view of the mantissa.
  assign mant32 = 32'({dec.mantissa, 32'b0} >> wordW);
  assign segment = mant32[30 -: seedIndexW];
  assign slope = oddScale ? seedSlopeOdd[segment] : seedSlopeEven[segment];
  assign intercept = oddScale ? seedInterceptOdd[segment] : seedInterceptEven[segment];

  // linear seed r0 = 2*(c - s*m) as a Q0.32 reciprocal root.
  assign slopeProd = slope * mant32;
  assign seedSum = intercept - slopeProd[62:31];
  assign seed32 = {seedSum[30:0], 1'b0};

  // r <- r*(3 - x*r^2)/2 with x = m or 2m.
  always_comb begin
    mantissaT            rVal;
    logic [2*wordW-1:0] rSq;
    logic [3*wordW-1:0] xr2;
    logic [wordW-1:0]   errFix;
    logic [2*wordW-1:0] stepProd;
    rVal = wordW'({seed32, {wordW{1'b0}}} >> 32);
    for (int i = 0; i < `SQRT_ITERS; i++) begin
      rSq = rVal * rVal;
      xr2 = oddScale ? (dec.mantissa * rSq) : (dec.mantissa * (rSq >> 1));
      errFix = wordW'((threeFix - xr2) >> (2 * wordW));
      stepProd = (rVal >> 1) * errFix;
      rVal = wordW'(stepProd >> (wordW - 2));
    end
    finalProd = dec.mantissa * (rVal >> 1);
  end

  // sqrt(m) = m/sqrt(m) is realigned so the hidden one lands at the msb.
  always_comb begin
    if (dec.mantissa[wordW-2:0] == '0) begin
      mantOut = oddScale ? sqrtTwoRoot : oneRoot;
    end else if (oddScale) begin
      mantOut = finalProd << 2;
    end else begin
      mantOut = finalProd << 1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rootValid <= 1'b0;
    end else begin
      rootValid <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec.valid) begin
      // floor halving leaves the spare factor of an odd scale in the mantissa.
      rootScale <= fullScale >>> 1;
      rootMant <= mantOut;
      rootZero <= dec.isZero;
      rootNaR <= dec.isNaR | negInput;
    end
  end

endmodule

// File: source/positDecoder.sv
`timescale 1ns/100ps
`include "posit_cfg.svh"

module positDecoder (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     inValid,
  input  positTypesPkg::positWordT inPosit,
  decodedPositIf.producer          dec
);
  import positTypesPkg::*;

  localparam int wordW = `POSIT_N;
  localparam int expW = `POSIT_ES;
  localparam int fracW = wordW - 1 - expW;

  logic               wordSign;
  logic               wordZero;
  logic               wordNaR;
  positWordT          absWord;
  logic [wordW-2:0]   body;
  logic               runBit;
  logic [`POSIT_RS:0] runLen;
  regimeT             kVal;
  logic [wordW-2:0]   tail;

  assign wordSign = inPosit[wordW-1];
  assign wordZero = (inPosit == '0);
  assign wordNaR = (inPosit == {1'b1, {(wordW-1){1'b0}}});

  // negative words are decoded from their two's complement.
  assign absWord = wordSign ? -inPosit : inPosit;
  assign body = absWord[wordW-2:0];
  assign runBit = body[wordW-2];

  // length of the leading regime run.
  always_comb begin
    logic stop;
    stop = 1'b0;
    runLen = '0;
    for (int i = wordW - 2; i >= 0; i--) begin
      if (!stop && (body[i] == runBit)) begin
        runLen = runLen + 1'b1;
      end else begin
        stop = 1'b1;
      end
    end
  end

  // a run of ones gives k = len-1, a run of zeros gives k = -len.
  assign kVal = runBit ? (regimeT'(runLen) - regimeT'(1)) : -regimeT'(runLen);

  // drop the run and its terminating bit.
  assign tail = body << (runLen + 1);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      dec.sign <= wordSign;
      dec.regime <= kVal;
      // exponent bits cut off by a long run read as zero.
      dec.exponent <= tail[wordW-2 -: expW];
      dec.mantissa <= {1'b1, tail[fracW-1:0], {expW{1'b0}}};
      dec.isZero <= wordZero;
      dec.isNaR <= wordNaR;
    end
  end

endmodule

// File: source/decodedPositIf.sv
`timescale 1ns/100ps

interface decodedPositIf;
  import positTypesPkg::*;

  logic     valid;
  logic     sign;
  regimeT   regime;
  exponentT exponent;
  mantissaT mantissa;
  logic     isZero;
  logic     isNaR;

  modport producer (
    output valid,
    output sign,
    output regime,
    output exponent,
    output mantissa,
    output isZero,
    output isNaR
  );

  modport consumer (
    input valid,
    input sign,
    input regime,
    input exponent,
    input mantissa,
    input isZero,
    input isNaR
  );

endinterface

// File: source/sqrtApproxPkg.sv
package sqrtApproxPkg;

  // the three fraction bits below the hidden one pick a segment.
  localparam int seedIndexW = 3;
  localparam int seedEntries = 1 << seedIndexW;

  // even scales approximate 1/sqrt(m).
  localparam logic [31:0] seedSlopeEven [seedEntries] = '{
    32'h3A904440, 32'h318B0307, 32'h2A9F9134, 32'h252D7982,
    32'h20CD01D7, 32'h1D386F55, 32'h1A3F5400, 32'h17BF1C04
  };

  localparam logic [31:0] seedInterceptEven [seedEntries] = '{
    32'hBA904440, 32'hB06A5AE0, 32'hA7C40C98, 32'hA0472C03,
    32'h99B67883, 32'h93E50A6F, 32'h8EB11A9C, 32'h8A00B1A2
  };

  // odd scales approximate 1/sqrt(2m).
  localparam logic [31:0] seedSlopeOdd [seedEntries] = '{
    32'h29692225, 32'h23083E61, 32'h1E23A4A6, 32'h1A49DEF0,
    32'h173194AA, 32'h14A9775B, 32'h128F4851, 32'h10CA945A
  };

  localparam logic [31:0] seedInterceptOdd [seedEntries] = '{
    32'h81F5CDDF, 32'h7CBE9B83, 32'h76A0DB59, 32'h71556B7F,
    32'h6CB0FC16, 32'h6893CC75, 32'h64E5FA23, 32'h619528B5
  };

endpackage

// File: source/positTypesPkg.sv
`include "posit_cfg.svh"

package positTypesPkg;

  // raw posit word as it appears on the ports.
  typedef logic [`POSIT_N-1:0] positWordT;

  // signed regime value k is one bit wider than the run counter.
  typedef logic signed [`POSIT_RS:0] regimeT;

  // exponent bits that follow the regime.
  typedef logic [`POSIT_ES-1:0] exponentT;

  // fraction left aligned behind the hidden one at the msb.
  typedef logic [`POSIT_N-1:0] mantissaT;

  // root significand with the hidden one at bit 2N-1.
  typedef logic [2*`POSIT_N-1:0] rootMantT;

  // combined scale k*2^ES + e.
  typedef logic signed [`POSIT_RS+`POSIT_ES+4:0] scaleT;

endpackage

// File: source/posit_cfg.svh
`ifndef POSIT_CFG_SVH
`define POSIT_CFG_SVH

// posit word width in bits.
`define POSIT_N 32

// exponent field width that sets useed to 2^(2^POSIT_ES).
`define POSIT_ES 2

// regime counter width that can count a run across the whole word.
`define POSIT_RS $clog2(`POSIT_N)

// newton refinement steps for the reciprocal square root.
`define SQRT_ITERS 3

`endif
